// ==== sim.f ====
src/qpu_pkg.sv
src/qpu_meas_regfile.sv
src/qpu_event_queue.sv
src/qpu_event_trigger.sv
src/qpu_exu_ctrl.sv
src/qpu_exu_top.sv
dv/tb_qpu_exu.sv

// ==== Bender.yml ====
package:
  name: qpu_exu

sources:
  - src/qpu_pkg.sv
  - src/qpu_meas_regfile.sv
  - src/qpu_event_queue.sv
  - src/qpu_event_trigger.sv
  - src/qpu_exu_ctrl.sv
  - src/qpu_exu_top.sv
  - target: test
    files:
      - dv/tb_qpu_exu.sv

// ==== dv/tb_qpu_exu.sv ====
// QPU execution stage testbench

`timescale 1ns/1ps
`default_nettype none

module tb_qpu_exu;
  import qpu_pkg::*;

  localparam int QUEUE_DEPTH = 8;
  localparam int CLK_PERIOD  = 40;
  // Stamping, equal stamps, conditions, hazard, back-pressure, random mix
  localparam int TEST_CYCLES     = 200 + 150 + 150 + 150 + 300 + 1500;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES * 3 / 2;

  typedef struct packed {
    logic         push;
    event_entry_t entry;
    qtime_t       time_next;
    qubit_mask_t  issue;
  } pred_t;

  logic         clk;
  logic         i_reset;
  logic         i_valid;
  qpu_instr_t   i_instr;
  logic         o_ready;
  logic         i_meas_wen;
  qubit_mask_t  i_meas_result;
  qtime_t       i_timer;
  logic         o_timer_ena;
  chan_mask_t   o_event_valid;
  edata_t       o_event_data;
  logic         o_active;

  logic         timer_run;
  qtime_t       timer_prev;   // Timer at the previous edge
  logic         exp_fire;     // Head was due at the previous edge
  qtime_t       m_time;       // Reference time point
  qubit_mask_t  m_pend;
  qubit_mask_t  m_res;
  event_entry_t exp_q[$];     // Events still to fire in push order
  logic [31:0]  rng;
  string        test_name;
  int           errors;
  int           test_errors;
  int           tests_run;

  qpu_exu_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    #1;
    if (timer_run) i_timer <= i_timer + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic is_dependent(input qpu_instr_t ins);
    return (ins.op == OP_MEASURE) || (ins.op == OP_QEVENT && ins.cond != COND_ALWAYS);
  endfunction

  // Effect of one accepted instruction on time, queue and scoreboard
  function automatic pred_t predict_instr(input qpu_instr_t ins, input qtime_t t,
                                          input qubit_mask_t res);
    pred_t p;
    logic  fire;
    p = '0;
    p.time_next   = t;
    p.entry.stamp = t;
    p.entry.chan  = ins.chan;
    p.entry.edata = ins.edata;
    case (ins.cond)
      COND_ALWAYS:  fire = 1'b1;
      COND_IF_ONE:  fire = res[ins.qidx];
      COND_IF_ZERO: fire = !res[ins.qidx];
      default:      fire = 1'b0;
    endcase
    case (ins.op)
      OP_QWAIT:   p.time_next = t + qtime_t'(ins.wait_inc);
      OP_QEVENT:  p.push = fire;
      OP_MEASURE: begin
        p.push  = 1'b1;
        p.issue = qubit_mask_t'(1) << ins.qidx;
      end
      default: ;
    endcase
    return p;
  endfunction

  function automatic qpu_instr_t make_instr(input int op, input int cond, input int q,
                                            input int ch, input int d, input int w);
    qpu_instr_t ins;
    ins.op       = qpu_op_e'(op);
    ins.cond     = qpu_cond_e'(cond);
    ins.qidx     = qidx_t'(q);
    ins.chan     = chan_mask_t'(ch);
    ins.edata    = edata_t'(d);
    ins.wait_inc = WAIT_WIDTH'(w);
    return ins;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Comparison and model update at every edge

  always @(posedge clk) begin : compare_proc
    pred_t        p;
    event_entry_t e;
    logic         exp_active;
    if (!i_reset) begin
      if ((o_event_valid != '0) !== exp_fire)
        note_error($sformatf("error %s: pulse expected %b, actual %b",
                             test_name, exp_fire, o_event_valid != '0));
      if (o_event_valid != '0) begin
        if (exp_q.size() == 0) begin
          note_error($sformatf("%s: pulse %h with no event queued", test_name, o_event_valid));
        end else begin
          e = exp_q.pop_front();
          if (o_event_valid !== e.chan)
            note_error($sformatf("error %s: channel expected %h, actual %h",
                                 test_name, e.chan, o_event_valid));
          if (o_event_data !== e.edata)
            note_error($sformatf("error %s: data expected %h, actual %h",
                                 test_name, e.edata, o_event_data));
          if (timer_prev < e.stamp)
            note_error($sformatf("%s: event stamped %0d fired at timer %0d",
                                 test_name, e.stamp, timer_prev));
        end
      end
      if (o_timer_ena !== (exp_q.size() != 0))
        note_error($sformatf("error %s: o_timer_ena expected %b, actual %b",
                             test_name, exp_q.size() != 0, o_timer_ena));
      exp_active = (exp_q.size() != 0) || (m_pend != '0) || i_valid;
      if (o_active !== exp_active)
        note_error($sformatf("error %s: o_active expected %b, actual %b",
                             test_name, exp_active, o_active));
      // Oldest queued event pops on the first edge its stamp is reached
      exp_fire = (exp_q.size() != 0) && (i_timer >= exp_q[0].stamp);
      p = '0;
      if (i_valid && o_ready) begin
        if (is_dependent(i_instr) && m_pend[i_instr.qidx])
          note_error($sformatf("%s: instruction accepted on a pending qubit", test_name));
        p = predict_instr(i_instr, m_time, m_res);
        if (p.push) exp_q.push_back(p.entry);
        m_time = p.time_next;
      end
      if (i_meas_wen) begin
        m_res  = (m_res & ~m_pend) | (i_meas_result & m_pend);
        m_pend = '0;
      end
      m_pend = m_pend | p.issue;
    end
    timer_prev = i_timer;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks

  task automatic send(input qpu_instr_t ins, input int max_cycles, output logic accepted);
    int n;
    n        = 0;
    accepted = 1'b0;
    i_valid  = 1'b1;
    i_instr  = ins;
    while (!accepted && n < max_cycles) begin
      @(posedge clk);
      accepted = o_ready;
      n++;
    end
    #2;
    i_valid = 1'b0;
  endtask

  task automatic issue(input qpu_instr_t ins);
    logic ok;
    send(ins, 200, ok);
    if (!ok) note_error($sformatf("%s: instruction %h was never accepted", test_name, ins));
  endtask

  task automatic meas_return(input qubit_mask_t mask);
    i_meas_wen    = 1'b1;
    i_meas_result = mask;
    @(posedge clk);
    #2;
    i_meas_wen = 1'b0;
  endtask

  // Offer an instruction on a pending qubit and release it after a while
  task automatic stall_then_return(input qpu_instr_t ins, input qubit_mask_t mask);
    fork
      issue(ins);
      begin
        repeat (5) begin
          @(posedge clk);
          if (o_ready) note_error($sformatf("%s: o_ready high on a pending qubit", test_name));
        end
        #2;
        meas_return(mask);
      end
    join
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || o_timer_ena) && n < 500) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (n >= 500) note_error($sformatf("%s: events still queued after drain", test_name));
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic finish_test();
    $display("%s: %0d errors", test_name, test_errors);
    errors      += test_errors;
    test_errors  = 0;
    tests_run++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic       ok;
    int         accepted;
    qpu_instr_t ins;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_instr = '0;
    i_meas_wen    = 1'b0;
    i_meas_result = '0;
    i_timer    = '0;
    timer_run  = 1'b0;
    timer_prev = '0;
    exp_fire   = 1'b0;
    m_time = '0;
    m_pend = '0;
    m_res  = '0;
    rng    = 32'h8e7a;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    test_name   = "reset";
    repeat (2) @(posedge clk);
    #2;
    i_reset = 1'b0;

    test_name = "stamping";
    timer_run = 1'b1;
    issue(make_instr(OP_QWAIT, COND_ALWAYS, 0, 0, 0, 20));
    issue(make_instr(OP_QEVENT, COND_ALWAYS, 0, 1, 8'h11, 0));
    issue(make_instr(OP_QWAIT, COND_ALWAYS, 0, 0, 0, 5));
    issue(make_instr(OP_QEVENT, COND_ALWAYS, 0, 2, 8'h22, 0));
    issue(make_instr(OP_QEVENT, COND_ALWAYS, 0, 4, 8'h33, 0));
    issue(make_instr(OP_QWAIT, COND_ALWAYS, 0, 0, 0, 10));
    issue(make_instr(OP_QEVENT, COND_ALWAYS, 0, 8, 8'h44, 0));
    drain();
    finish_test();

    test_name = "equal_stamps";
    issue(make_instr(OP_QWAIT, COND_ALWAYS, 0, 0, 0, 30));
    for (int i = 0; i < 4; i++) issue(make_instr(OP_QEVENT, COND_ALWAYS, 0, 1 << i, 8'h20 + i, 0));
    drain();
    finish_test();

    test_name = "conditions";
    issue(make_instr(OP_MEASURE, COND_ALWAYS, 2, 1, 8'h30, 0));
    issue(make_instr(OP_MEASURE, COND_ALWAYS, 5, 2, 8'h31, 0));
    meas_return(8'b0000_0100);   // Qubit 2 reads one, qubit 5 zero
    issue(make_instr(OP_QEVENT, COND_IF_ONE, 2, 4, 8'h32, 0));
    issue(make_instr(OP_QEVENT, COND_IF_ZERO, 2, 8, 8'h33, 0));
    issue(make_instr(OP_QEVENT, COND_IF_ONE, 5, 3, 8'h34, 0));
    issue(make_instr(OP_QEVENT, COND_IF_ZERO, 5, 5, 8'h35, 0));
    drain();
    finish_test();

    test_name = "hazard";
    issue(make_instr(OP_MEASURE, COND_ALWAYS, 1, 2, 8'h40, 0));
    stall_then_return(make_instr(OP_QEVENT, COND_IF_ONE, 1, 4, 8'h41, 0), 8'h02);
    issue(make_instr(OP_MEASURE, COND_ALWAYS, 3, 1, 8'h42, 0));
    stall_then_return(make_instr(OP_MEASURE, COND_ALWAYS, 3, 8, 8'h43, 0), 8'h08);
    meas_return(8'h00);
    issue(make_instr(OP_QEVENT, COND_IF_ZERO, 3, 6, 8'h44, 0));
    drain();
    finish_test();

    test_name = "backpressure";
    timer_run = 1'b0;
    i_timer   = '0;
    issue(make_instr(OP_QWAIT, COND_ALWAYS, 0, 0, 0, 1));
    accepted = 0;
    ok       = 1'b1;
    while (ok && accepted < QUEUE_DEPTH + 2) begin
      send(make_instr(OP_QEVENT, COND_ALWAYS, 0, 4'h5, 8'h50 + accepted, 0), 10, ok);
      if (ok) accepted++;
    end
    if (accepted != QUEUE_DEPTH)
      note_error($sformatf("error %s: accepted expected %0d, actual %0d",
                           test_name, QUEUE_DEPTH, accepted));
    timer_run = 1'b1;
    drain();
    finish_test();

    test_name = "random";
    for (int i = 0; i < 300; i++) begin
      rng = xorshift(rng);
      ins = make_instr(rng[1:0], rng[3:2] % 3, rng[6:4], 1 + rng[10:7] % 15,
                       rng[18:11], rng[21:19]);
      if ((is_dependent(ins) && m_pend[ins.qidx]) || rng[24:22] == 3'd0) meas_return(rng[31:24]);
      issue(ins);
    end
    if (m_pend != '0) meas_return(rng[15:8]);
    drain();
    if (o_active) note_error($sformatf("%s: o_active still high after drain", test_name));
    finish_test();

    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog timeout during %s, run did not finish", test_name);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/qpu_exu_top.sv ====
// QPU execution stage top

`timescale 1ns/1ps
`default_nettype none

module qpu_exu_top #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 i_reset,

  // Instruction link
  input  logic                 i_valid,
  input  qpu_pkg::qpu_instr_t  i_instr,
  output logic                 o_ready,

  // Measurement unit return
  input  logic                 i_meas_wen,
  input  qpu_pkg::qubit_mask_t i_meas_result,

  // Trigger side
  input  qpu_pkg::qtime_t      i_timer,
  output logic                 o_timer_ena,
  output qpu_pkg::chan_mask_t  o_event_valid,
  output qpu_pkg::edata_t      o_event_data,

  output logic                 o_active
);
  import qpu_pkg::*;

  qubit_mask_t  pending;
  qubit_mask_t  result;
  logic         meas_issue;
  qidx_t        meas_qidx;

  logic         push;
  event_entry_t push_entry;
  logic         full;

  event_entry_t head;
  logic         not_empty;
  logic         pop;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and dispatch

  qpu_exu_ctrl u_ctrl (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_instr      (i_instr),
    .o_ready      (o_ready),
    .i_pending    (pending),
    .i_result     (result),
    .i_full       (full),
    .o_push       (push),
    .o_entry      (push_entry),
    .o_meas_issue (meas_issue),
    .o_meas_qidx  (meas_qidx)
  );

  qpu_meas_regfile u_meas (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_meas_issue  (meas_issue),
    .i_meas_qidx   (meas_qidx),
    .i_meas_wen    (i_meas_wen),
    .i_meas_result (i_meas_result),
    .o_pending     (pending),
    .o_result      (result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stamped event queue and trigger

  qpu_event_queue #(
    .DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_push      (push),
    .i_entry     (push_entry),
    .i_pop       (pop),
    .o_head      (head),
    .o_not_empty (not_empty),
    .o_full      (full)
  );

  qpu_event_trigger u_trigger (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_head        (head),
    .i_not_empty   (not_empty),
    .i_timer       (i_timer),
    .o_pop         (pop),
    .o_event_valid (o_event_valid),
    .o_event_data  (o_event_data)
  );

  assign o_timer_ena = not_empty;  // Timer only needed while events wait

  // Busy while events wait, a readout is outstanding, or work is offered
  assign o_active = not_empty | (|pending) | i_valid;

endmodule

`default_nettype wire

// ==== src/qpu_exu_ctrl.sv ====
// QPU decode and dispatch control

`timescale 1ns/1ps
`default_nettype none

module qpu_exu_ctrl (
  input  logic                  clk,
  input  logic                  i_reset,

  input  logic                  i_valid,
  input  qpu_pkg::qpu_instr_t   i_instr,
  output logic                  o_ready,

  // Scoreboard and stored results
  input  qpu_pkg::qubit_mask_t  i_pending,
  input  qpu_pkg::qubit_mask_t  i_result,

  // Event queue
  input  logic                  i_full,
  output logic                  o_push,
  output qpu_pkg::event_entry_t o_entry,

  // Measure issue
  output logic                  o_meas_issue,
  output qpu_pkg::qidx_t        o_meas_qidx
);
  import qpu_pkg::*;

  qtime_t time_q;     // Current time point
  logic   run_q;      // Holds o_ready low through reset

  logic   is_wait;
  logic   is_event;
  logic   is_meas;
  logic   uses_queue;
  logic   qubit_dep;
  logic   qubit_busy;
  logic   cond_true;
  logic   stall;
  logic   accept;

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  assign is_wait  = (i_instr.op == OP_QWAIT);
  assign is_event = (i_instr.op == OP_QEVENT);
  assign is_meas  = (i_instr.op == OP_MEASURE);

  assign uses_queue = is_event | is_meas;

  // Measures and conditional events both depend on the addressed qubit
  assign qubit_dep  = is_meas | (is_event & (i_instr.cond != COND_ALWAYS));
  assign qubit_busy = i_pending[i_instr.qidx];

  // Condition against the stored result
  always_comb begin
    case (i_instr.cond)
      COND_ALWAYS:  cond_true = 1'b1;
      COND_IF_ONE:  cond_true = i_result[i_instr.qidx];
      COND_IF_ZERO: cond_true = ~i_result[i_instr.qidx];
      default:      cond_true = 1'b0;  // Reserved
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hazard stall and handshake

  // A full queue stalls queue users even when the condition is false
  assign stall  = (uses_queue & i_full) | (qubit_dep & qubit_busy);
  assign o_ready = run_q & ~stall;
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Time point register

  always_ff @(posedge clk) begin
    if (i_reset) begin
      time_q <= '0;
    end else if (accept && is_wait) begin
      time_q <= time_q + qtime_t'(i_instr.wait_inc);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch

  // False condition consumes the instruction silently
  assign o_push = accept & (is_meas | (is_event & cond_true));

  assign o_entry.stamp = time_q;        // Stamp before any advance
  assign o_entry.chan  = i_instr.chan;
  assign o_entry.edata = i_instr.edata;

  assign o_meas_issue = accept & is_meas;
  assign o_meas_qidx  = i_instr.qidx;

  // A stalled instruction stays on the link unchanged
  a_instr_hold: assert property (
    @(posedge clk) disable iff (i_reset)
      (i_valid && !o_ready) |=> (!i_valid || $stable(i_instr))
  );

endmodule

`default_nettype wire

// ==== src/qpu_event_trigger.sv ====
// Timer compare and event pulse stage

`timescale 1ns/1ps
`default_nettype none

module qpu_event_trigger (
  input  logic                  clk,
  input  logic                  i_reset,

  // Queue head
  input  qpu_pkg::event_entry_t i_head,
  input  logic                  i_not_empty,
  input  qpu_pkg::qtime_t       i_timer,
  output logic                  o_pop,

  // One-cycle event pulses
  output qpu_pkg::chan_mask_t   o_event_valid,
  output qpu_pkg::edata_t       o_event_data
);

  logic due;

  ////////////////////////////////////////////////////////////////////////////
  // Head compare

  // Head fires once the unsigned timer reaches its stamp
  assign due   = i_not_empty && (i_timer >= i_head.stamp);
  assign o_pop = due;  // At most one entry per cycle

  ////////////////////////////////////////////////////////////////////////////
  // Output pulse register

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_event_valid <= '0;
      o_event_data  <= '0;
    end else if (due) begin
      o_event_valid <= i_head.chan;
      o_event_data  <= i_head.edata;
    end else begin
      o_event_valid <= '0;  // Pulse lasts one cycle
      o_event_data  <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/qpu_event_queue.sv ====
// Stamped event FIFO

`timescale 1ns/1ps
`default_nettype none

module qpu_event_queue #(
  parameter int DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  i_reset,

  input  logic                  i_push,
  input  qpu_pkg::event_entry_t i_entry,
  input  logic                  i_pop,

  output qpu_pkg::event_entry_t o_head,
  output logic                  o_not_empty,
  output logic                  o_full
);
  import qpu_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  event_entry_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Circular increment for any DEPTH, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= ptr_next(wr_ptr);
      if (i_pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign o_head      = mem[rd_ptr];  // Fall-through head
  assign o_not_empty = (count != '0);
  assign o_full      = (count == CNT_W'(DEPTH));

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (i_reset) i_pop |-> o_not_empty
  );

  a_no_push_full: assert property (
    @(posedge clk) disable iff (i_reset) (i_push && o_full) |-> i_pop
  );

endmodule

`default_nettype wire

// ==== src/qpu_meas_regfile.sv ====
// Measurement results and qubit scoreboard

`timescale 1ns/1ps
`default_nettype none

module qpu_meas_regfile (
  input  logic                 clk,
  input  logic                 i_reset,

  // Issue from control
  input  logic                 i_meas_issue,
  input  qpu_pkg::qidx_t       i_meas_qidx,

  // Return from the measurement unit
  input  logic                 i_meas_wen,
  input  qpu_pkg::qubit_mask_t i_meas_result,

  output qpu_pkg::qubit_mask_t o_pending,
  output qpu_pkg::qubit_mask_t o_result
);
  import qpu_pkg::*;

  qubit_mask_t pending_q;
  qubit_mask_t result_q;
  qubit_mask_t issue_mask;
  qubit_mask_t ret_mask;

  assign issue_mask = i_meas_issue ? (qubit_mask_t'(1) << i_meas_qidx) : '0;

  // Every pending qubit completes on a return strobe
  assign ret_mask = i_meas_wen ? pending_q : '0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pending_q <= '0;
      result_q  <= '0;
    end else begin
      pending_q <= (pending_q & ~ret_mask) | issue_mask;  // New issue wins
      result_q  <= (result_q & ~ret_mask) | (i_meas_result & ret_mask);
    end
  end

  assign o_pending = pending_q;
  assign o_result  = result_q;

  // Control must hold a measure while its qubit is still outstanding
  a_issue_not_pending: assert property (
    @(posedge clk) disable iff (i_reset)
      i_meas_issue |-> !pending_q[i_meas_qidx]
  );

endmodule

`default_nettype wire

// ==== src/qpu_pkg.sv ====
// QPU execution stage definitions

`default_nettype none

package qpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths fixed by the instruction encoding

  localparam int QUBIT_NUM   = 8;
  localparam int QIDX_WIDTH  = 3;   // Selects one of QUBIT_NUM
  localparam int EVENT_NUM   = 4;
  localparam int EDATA_WIDTH = 8;
  localparam int TIME_WIDTH  = 16;
  localparam int WAIT_WIDTH  = 11;  // Wait increment field

  typedef logic [QUBIT_NUM-1:0]   qubit_mask_t;
  typedef logic [QIDX_WIDTH-1:0]  qidx_t;
  typedef logic [EVENT_NUM-1:0]   chan_mask_t;
  typedef logic [EDATA_WIDTH-1:0] edata_t;
  typedef logic [TIME_WIDTH-1:0]  qtime_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoding

  typedef enum logic [3:0] {
    OP_NOP     = 4'h0,
    OP_QWAIT   = 4'h1,  // Advance the time point
    OP_QEVENT  = 4'h2,  // Queue an event at the current time point
    OP_MEASURE = 4'h3   // Mark qubit pending, queue the readout pulse
  } qpu_op_e;

  // Encoding 2'b11 is reserved and never fires
  typedef enum logic [1:0] {
    COND_ALWAYS  = 2'b00,
    COND_IF_ONE  = 2'b01,
    COND_IF_ZERO = 2'b10
  } qpu_cond_e;

  // 4 + 2 + 3 + 4 + 8 + 11 = 32 bits
  typedef struct packed {
    qpu_op_e                 op;
    qpu_cond_e               cond;
    qidx_t                   qidx;      // Measured or tested qubit
    chan_mask_t              chan;      // Event channels to pulse
    edata_t                  edata;
    logic [WAIT_WIDTH-1:0]   wait_inc;  // Time increment for OP_QWAIT
  } qpu_instr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Event queue entry

  typedef struct packed {
    qtime_t     stamp;  // Time point at issue
    chan_mask_t chan;
    edata_t     edata;
  } event_entry_t;

endpackage

`default_nettype wire
